// File: logic/mipsPkg.sv
package mipsPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Machine word
    localparam int dataWidth = 32;
    // Register index into the 32 entry file
    localparam int regAddrW = 5;
    // Word address on the program load port
    localparam int progAddrW = 8;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        rType = 6'h00,
        j     = 6'h02,
        jal   = 6'h03,
        beq   = 6'h04,
        bne   = 6'h05,
        addi  = 6'h08,
        ori   = 6'h0D,
        lw    = 6'h23,
        sw    = 6'h2B,
        // Stops the core once it reaches the result stage
        halt  = 6'h3F
    } opcodeE;

    // Functions the execute ALU knows
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll
    } aluOpE;

    //////////////////////////////////////////////////////////////////////
    // Pipeline registers
    //////////////////////////////////////////////////////////////////////

    // Decode to execute
    typedef struct packed {
        logic                 valid;
        aluOpE                aluOp;
        // Register operands as read in decode
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        // Already sign or zero extended
        logic [dataWidth-1:0] imm;
        logic [4:0]           shamt;
        logic                 useImm;
        logic [regAddrW-1:0]  dest;
        logic                 regWrite;
        logic                 memRead;
        logic                 memWrite;
        // jal writes PC plus 4 instead of the ALU result
        logic                 link;
        logic [dataWidth-1:0] pc4;
        logic                 isHalt;
    } decExT;

    // Execute to result
    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] storeData;
        logic [regAddrW-1:0]  dest;
        logic                 regWrite;
        logic                 memRead;
        logic                 memWrite;
        logic                 link;
        logic [dataWidth-1:0] pc4;
        logic                 isHalt;
    } exResT;

    //////////////////////////////////////////////////////////////////////
    // Ports
    //////////////////////////////////////////////////////////////////////

    // Register file write port, also the retire trace
    typedef struct packed {
        logic                 en;
        logic [regAddrW-1:0]  idx;
        logic [dataWidth-1:0] data;
    } regWriteT;

    // One instruction word per cycle into instruction memory
    typedef struct packed {
        logic                 valid;
        logic [progAddrW-1:0] addr;
        logic [dataWidth-1:0] instr;
    } progLoadT;

endpackage

// File: logic/fetchStage.sv
`timescale 1ns/1ns

module fetchStage #(
    parameter int imemWords = 64
) (
    input  logic                           Clk,
    input  logic                           arstN,
    input  mipsPkg::progLoadT              progLoad,
    input  logic                           run,
    input  logic                           stall,
    input  logic                           redirect,
    input  logic [mipsPkg::dataWidth-1:0]  redirectPc,
    input  logic                           stop,
    output logic                           fetchValid,
    output logic [mipsPkg::dataWidth-1:0]  fetchInstr,
    output logic [mipsPkg::dataWidth-1:0]  fetchPc4
);

    // Word index width into instruction memory
    localparam int iaW = $clog2(imemWords);

    logic [mipsPkg::dataWidth-1:0] pcQ;
    logic [mipsPkg::dataWidth-1:0] imem [imemWords];

    // Loader writes one word per cycle before the core runs
    always_ff @(posedge Clk) begin
        if (progLoad.valid) begin
            imem[progLoad.addr[iaW-1:0]] <= progLoad.instr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program counter and fetch valid
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pcQ        <= '0;
            fetchValid <= 1'b0;
        end else if (!run) begin
            // Idle core sits at address zero
            pcQ        <= '0;
            fetchValid <= 1'b0;
        end else if (stop) begin
            fetchValid <= 1'b0;
        end else if (redirect) begin
            // Word fetched this cycle is wrong path
            pcQ        <= redirectPc;
            fetchValid <= 1'b0;
        end else if (!stall) begin
            pcQ        <= pcQ + 4;
            fetchValid <= 1'b1;
        end
    end

    // Instruction and PC plus 4 only follow the PC when it advances
    always_ff @(posedge Clk) begin
        if (run && !stop && !redirect && !stall) begin
            fetchInstr <= imem[pcQ[iaW+1:2]];
            fetchPc4   <= pcQ + 4;
        end
    end

endmodule

// File: logic/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic                           Clk,
    input  logic                           arstN,
    input  logic                           fetchValid,
    input  logic [mipsPkg::dataWidth-1:0]  fetchInstr,
    input  logic [mipsPkg::dataWidth-1:0]  fetchPc4,
    input  logic [mipsPkg::regAddrW-1:0]   exDest,
    input  logic                           exRegWrite,
    input  mipsPkg::regWriteT              wbWrite,
    output logic                           stall,
    output logic                           redirect,
    output logic [mipsPkg::dataWidth-1:0]  redirectPc,
    output mipsPkg::decExT                 decOut
);

    // Instruction fields
    mipsPkg::opcodeE               op;
    logic [mipsPkg::regAddrW-1:0]  rs;
    logic [mipsPkg::regAddrW-1:0]  rt;
    logic [mipsPkg::regAddrW-1:0]  rd;
    logic [4:0]                    shamt;
    logic [5:0]                    funct;
    logic [15:0]                   imm16;
    logic [25:0]                   jIdx;

    // Register file and its read ports
    logic [mipsPkg::dataWidth-1:0] regs [32];
    logic [mipsPkg::dataWidth-1:0] rsVal;
    logic [mipsPkg::dataWidth-1:0] rtVal;

    // Control
    mipsPkg::aluOpE                aluOp;
    logic                          useImm;
    logic                          zeroExt;
    logic                          regWrite;
    logic                          memRead;
    logic                          memWrite;
    logic                          link;
    logic                          isHalt;
    logic                          isJump;
    logic                          taken;
    logic [mipsPkg::regAddrW-1:0]  dest;

    mipsPkg::decExT                decNext;

    assign op    = mipsPkg::opcodeE'(fetchInstr[31:26]);
    assign rs    = fetchInstr[25:21];
    assign rt    = fetchInstr[20:16];
    assign rd    = fetchInstr[15:11];
    assign shamt = fetchInstr[10:6];
    assign funct = fetchInstr[5:0];
    assign imm16 = fetchInstr[15:0];
    assign jIdx  = fetchInstr[25:0];

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    // Result stage never sends a write to register zero
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite.en) begin
            regs[wbWrite.idx] <= wbWrite.data;
        end
    end

    // Write through so a same cycle write is seen by decode
    assign rsVal = (wbWrite.en && wbWrite.idx == rs) ? wbWrite.data : regs[rs];
    assign rtVal = (wbWrite.en && wbWrite.idx == rt) ? wbWrite.data : regs[rt];

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        aluOp    = mipsPkg::aluAdd;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        link     = 1'b0;
        isHalt   = 1'b0;
        isJump   = 1'b0;
        dest     = rt;
        case (op)
            mipsPkg::rType: begin
                regWrite = 1'b1;
                dest     = rd;
                case (funct)
                    6'h22:   aluOp = mipsPkg::aluSub;
                    6'h24:   aluOp = mipsPkg::aluAnd;
                    6'h25:   aluOp = mipsPkg::aluOr;
                    6'h2A:   aluOp = mipsPkg::aluSlt;
                    6'h00:   aluOp = mipsPkg::aluSll;
                    default: aluOp = mipsPkg::aluAdd;
                endcase
            end
            mipsPkg::addi: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::ori: begin
                aluOp    = mipsPkg::aluOr;
                useImm   = 1'b1;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            // Address is base plus offset
            mipsPkg::lw: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            mipsPkg::sw: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            mipsPkg::j: isJump = 1'b1;
            mipsPkg::jal: begin
                isJump   = 1'b1;
                link     = 1'b1;
                regWrite = 1'b1;
                dest     = 5'd31;
            end
            mipsPkg::halt: isHalt = 1'b1;
            // beq, bne and unknown opcodes write nothing
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Hazard, branch and jump
    //////////////////////////////////////////////////////////////////////

    // Older instruction in execute still owes a source register
    assign stall = fetchValid && exRegWrite && exDest != '0 &&
                   (exDest == rs || exDest == rt);

    assign taken = (op == mipsPkg::beq && rsVal == rtVal) ||
                   (op == mipsPkg::bne && rsVal != rtVal);

    // Operands may be stale while stalled so no redirect then
    assign redirect = fetchValid && !stall && (taken || isJump);

    // Jump keeps the top PC nibble, branch adds the word offset
    assign redirectPc = isJump ? {fetchPc4[31:28], jIdx, 2'b00}
                               : fetchPc4 + {{14{imm16[15]}}, imm16, 2'b00};

    //////////////////////////////////////////////////////////////////////
    // Decode to execute register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        decNext          = '0;
        // Stall sends a bubble to execute
        decNext.valid    = fetchValid && !stall;
        decNext.aluOp    = aluOp;
        decNext.opA      = rsVal;
        decNext.opB      = rtVal;
        decNext.imm      = zeroExt ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
        decNext.shamt    = shamt;
        decNext.useImm   = useImm;
        decNext.dest     = dest;
        decNext.regWrite = regWrite;
        decNext.memRead  = memRead;
        decNext.memWrite = memWrite;
        decNext.link     = link;
        decNext.pc4      = fetchPc4;
        decNext.isHalt   = isHalt;
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            decOut <= '0;
        end else begin
            decOut <= decNext;
        end
    end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic                          Clk,
    input  logic                          arstN,
    input  mipsPkg::decExT                decIn,
    output logic [mipsPkg::regAddrW-1:0]  exDest,
    output logic                          exRegWrite,
    output mipsPkg::exResT                exOut
);

    logic [mipsPkg::dataWidth-1:0] opB;
    logic [mipsPkg::dataWidth-1:0] aluResult;

    // Seen by decode for the hazard check
    assign exDest     = decIn.dest;
    assign exRegWrite = decIn.valid && decIn.regWrite;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    // Immediate replaces rt for I-type
    assign opB = decIn.useImm ? decIn.imm : decIn.opB;

    always_comb begin
        case (decIn.aluOp)
            mipsPkg::aluSub: aluResult = decIn.opA - opB;
            mipsPkg::aluAnd: aluResult = decIn.opA & opB;
            mipsPkg::aluOr:  aluResult = decIn.opA | opB;
            mipsPkg::aluSlt: begin
                aluResult = ($signed(decIn.opA) < $signed(opB)) ? 32'd1 : 32'd0;
            end
            // sll shifts rt by the shamt field
            mipsPkg::aluSll: aluResult = opB << decIn.shamt;
            default:         aluResult = decIn.opA + opB;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Execute to result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            exOut <= '0;
        end else begin
            exOut.valid     <= decIn.valid;
            exOut.aluResult <= aluResult;
            // Store data is rt regardless of the immediate select
            exOut.storeData <= decIn.opB;
            exOut.dest      <= decIn.dest;
            exOut.regWrite  <= decIn.regWrite;
            exOut.memRead   <= decIn.memRead;
            exOut.memWrite  <= decIn.memWrite;
            exOut.link      <= decIn.link;
            exOut.pc4       <= decIn.pc4;
            exOut.isHalt    <= decIn.isHalt;
        end
    end

endmodule

// File: logic/resultStage.sv
`timescale 1ns/1ns

module resultStage #(
    parameter int dmemWords = 64
) (
    input  logic               Clk,
    input  logic               arstN,
    input  mipsPkg::exResT     exIn,
    output mipsPkg::regWriteT  wbWrite,
    output logic               halted,
    output logic               stop
);

    // Word index width into data memory
    localparam int daW = $clog2(dmemWords);

    logic [mipsPkg::dataWidth-1:0] dmem [dmemWords];
    logic [daW-1:0]                dIdx;
    logic                          live;

    assign dIdx = exIn.aluResult[daW+1:2];

    // Nothing retires once the core has halted
    assign live = exIn.valid && !halted;

    //////////////////////////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (live && exIn.memWrite) begin
            dmem[dIdx] <= exIn.storeData;
        end
    end

    // Write-back data prefers the link address, then load data, then the ALU result
    assign wbWrite.en   = live && exIn.regWrite && exIn.dest != '0;
    assign wbWrite.idx  = exIn.dest;
    assign wbWrite.data = exIn.link    ? exIn.pc4 :
                          exIn.memRead ? dmem[dIdx] : exIn.aluResult;

    // Sticky until reset
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            halted <= 1'b0;
        end else if (exIn.valid && exIn.isHalt) begin
            halted <= 1'b1;
        end
    end

    // Fetch stops as soon as halt is seen here
    assign stop = halted || (exIn.valid && exIn.isHalt);

endmodule

// File: logic/mipsCore.sv
`timescale 1ns/1ns

module mipsCore #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  logic               Clk,
    input  logic               arstN,
    input  mipsPkg::progLoadT  progLoad,
    input  logic               run,
    output mipsPkg::regWriteT  trace,
    output logic               halted
);

    //////////////////////////////////////////////////////////////////////
    // Stage to stage wires
    //////////////////////////////////////////////////////////////////////

    // Fetch to decode
    logic                          fetchValid;
    logic [mipsPkg::dataWidth-1:0] fetchInstr;
    logic [mipsPkg::dataWidth-1:0] fetchPc4;

    // Decode back to fetch
    logic                          stall;
    logic                          redirect;
    logic [mipsPkg::dataWidth-1:0] redirectPc;

    // Execute back to decode for hazards
    logic [mipsPkg::regAddrW-1:0]  exDest;
    logic                          exRegWrite;

    mipsPkg::decExT                decEx;
    mipsPkg::exResT                exRes;
    mipsPkg::regWriteT             wbWrite;
    logic                          stop;

    // Every register write is also the retire trace
    assign trace = wbWrite;

    fetchStage #(.imemWords(imemWords)) fetch (
        .Clk(Clk), .arstN(arstN), .progLoad(progLoad), .run(run),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc), .stop(stop),
        .fetchValid(fetchValid), .fetchInstr(fetchInstr), .fetchPc4(fetchPc4)
    );

    decodeStage decode (
        .Clk(Clk), .arstN(arstN), .fetchValid(fetchValid),
        .fetchInstr(fetchInstr), .fetchPc4(fetchPc4),
        .exDest(exDest), .exRegWrite(exRegWrite), .wbWrite(wbWrite),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc), .decOut(decEx)
    );

    executeStage execute (
        .Clk(Clk), .arstN(arstN), .decIn(decEx),
        .exDest(exDest), .exRegWrite(exRegWrite), .exOut(exRes)
    );

    resultStage #(.dmemWords(dmemWords)) result (
        .Clk(Clk), .arstN(arstN), .exIn(exRes),
        .wbWrite(wbWrite), .halted(halted), .stop(stop)
    );

endmodule

// File: testbench/coreTb.sv
`timescale 1ns/1ns

module coreTb;

    // Memory depths handed to the DUT
    localparam int imemWords = 64;
    localparam int dmemWords = 64;
    // Limit on every wait for the DUT
    localparam int timeoutCycles = 500;
    // Quiet cycles watched once the core has halted
    localparam int drainCycles = 10;

    logic              Clk;
    logic              arstN;
    logic              run;
    mipsPkg::progLoadT progLoad;
    mipsPkg::regWriteT trace;
    logic              halted;

    // Test currently parsed from the input file
    logic [8*24-1:0] testName;
    logic [31:0]     progQ [$];
    logic [31:0]     expIdxQ [$];
    logic [31:0]     expValQ [$];
    int              testErrors;
    int              testsRun;
    int              testsFailed;

    mipsCore #(.imemWords(imemWords), .dmemWords(dmemWords)) UUT (
        .Clk(Clk), .arstN(arstN), .progLoad(progLoad), .run(run),
        .trace(trace), .halted(halted)
    );

    // 10 ns clock
    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %0s %0s expected %h actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    // Five cycles of reset with the core idle
    task automatic applyReset();
        @(posedge Clk);
        arstN    <= 1'b0;
        run      <= 1'b0;
        progLoad <= '0;
        repeat (5) @(posedge Clk);
        arstN <= 1'b1;
    endtask

    // One word per cycle, then start the core
    task automatic loadProgram();
        foreach (progQ[i]) begin
            @(posedge Clk);
            progLoad.valid <= 1'b1;
            progLoad.addr  <= 8'(i);
            progLoad.instr <= progQ[i];
        end
        @(posedge Clk);
        progLoad <= '0;
        run      <= 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // One test from reset to the quiet cycles after halt
    //////////////////////////////////////////////////////////////////////

    task automatic executeTest();
        int cycles;
        bit gotWrite;
        bit aborted;
        testErrors = 0;
        aborted    = 1'b0;
        applyReset();
        loadProgram();
        // Trace is sampled on the falling edge, one sample per cycle
        foreach (expIdxQ[k]) begin
            if (!aborted) begin
                cycles   = 0;
                gotWrite = 1'b0;
                while (!gotWrite && !halted && cycles < timeoutCycles) begin
                    @(negedge Clk);
                    gotWrite = trace.en;
                    cycles++;
                end
                if (gotWrite) begin
                    compareValue("register", expIdxQ[k], 32'(trace.idx));
                    compareValue("value", expValQ[k], trace.data);
                end else begin
                    if (halted) begin
                        $display("%0s halted before write %0d was seen", testName, k);
                    end else begin
                        $display("%0s timed out waiting for write %0d", testName, k);
                    end
                    testErrors++;
                    aborted = 1'b1;
                end
            end
        end
        // Every expected write is in, so nothing else may retire before halt
        cycles = 0;
        while (!aborted && !halted && cycles < timeoutCycles) begin
            @(negedge Clk);
            if (trace.en) begin
                $display("%0s wrote register %0d although no write was expected",
                         testName, trace.idx);
                testErrors++;
            end
            cycles++;
        end
        if (!aborted && !halted) begin
            $display("%0s timed out waiting for the core to halt", testName);
            testErrors++;
            aborted = 1'b1;
        end
        if (!aborted) begin
            repeat (drainCycles) begin
                @(negedge Clk);
                if (trace.en) begin
                    $display("%0s wrote register %0d after halt", testName, trace.idx);
                    testErrors++;
                end
                if (!halted) begin
                    $display("%0s dropped the halted flag", testName);
                    testErrors++;
                end
            end
        end
        testsRun++;
        if (testErrors == 0) begin
            $display("test %0s passed", testName);
        end else begin
            $display("test %0s failed with %0d errors", testName, testErrors);
            testsFailed++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Input file reader
    //////////////////////////////////////////////////////////////////////

    // Single letter tag at the start of each line picks its meaning
    task automatic parseInputFile(input int fd);
        int           n;
        int           count;
        logic [7:0]   tag;
        logic [8*128-1:0] rest;
        logic [31:0]  word;
        logic [31:0]  regIdx;
        n = $fscanf(fd, "%s", tag);
        while (n == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "t") begin
                n = $fscanf(fd, "%s", testName);
                progQ.delete();
                expIdxQ.delete();
                expValQ.delete();
            end else if (tag == "p") begin
                n = $fscanf(fd, "%d", count);
                repeat (count) begin
                    n = $fscanf(fd, "%h", word);
                    progQ.push_back(word);
                end
            end else if (tag == "w") begin
                n = $fscanf(fd, "%d", count);
                // Pairs of register number and written value
                repeat (count) begin
                    n = $fscanf(fd, "%d %h", regIdx, word);
                    expIdxQ.push_back(regIdx);
                    expValQ.push_back(word);
                end
            end else if (tag == "e") begin
                executeTest();
            end else begin
                $display("unknown line tag %c in the input file", tag);
                testsFailed++;
            end
            n = $fscanf(fd, "%s", tag);
        end
    endtask

    initial begin
        int fd;
        arstN       <= 1'b0;
        run         <= 1'b0;
        progLoad    <= '0;
        testsRun    = 0;
        testsFailed = 0;
        fd = $fopen("testbench/coreInput.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/coreInput.txt");
            $display("TEST RESULT: FAIL");
        end else begin
            parseInputFile(fd);
            $fclose(fd);
            $display("%0d tests run, %0d passed, %0d failed",
                     testsRun, testsRun - testsFailed, testsFailed);
            if (testsFailed == 0 && testsRun > 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

// File: testbench/coreInput.txt
# t <test name>, p <count> <instruction words in hex>, e ends the test
# w <count> then pairs of register number (decimal) and written value (hex), in retire order
t aluImm
p 5 20010005 340200f3 2003fffd 00222020 00412822
p 5 00413024 00223825 0061402a 00014900 fc000000
w 9 1 5 2 f3 3 fffffffd 4 f8 5 ee 6 1 7 f7 8 1 9 50
e
t hazardStall
p 5 20010007 00211020 00411820 20640064 fc000000
w 4 1 7 2 e 3 15 4 79
e
t memory
p 6 20011234 20020008 ac410004 8c03000c 00612020 fc000000
w 4 1 1234 2 8 3 1234 4 2468
e
t branches
p 5 20010003 20020003 10220002 200a0001 200b0002
p 5 20030033 14220001 20040044 20050055 fc000000
w 5 1 3 2 3 3 33 4 44 5 55
e
t jumpLink
p 7 20010001 08000003 200a00aa 0c000005 200b00bb 23e20001 fc000000
w 3 1 1 31 10 2 11
e
t haltZero
p 6 20000055 20010009 00210020 fc000000 20020066 20030077
w 1 1 9
e

// File: sim.f
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/resultStage.sv
logic/mipsCore.sv
testbench/coreTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module coreTb -f sim.f -o coreSim
out=$(./obj_dir/coreSim)
echo "$out"
if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
